// File: exu_pkg.sv
package exu_pkg;

	localparam int data_width = 32;

	// Iteration counts set the multiply and divide latency.
	localparam int mul_steps = 32;
	localparam int div_steps = 32;

	typedef enum logic [4:0] {
		op_add,
		op_sub,
		op_sll,
		op_slt,
		op_sltu,
		op_xor,
		op_srl,
		op_sra,
		op_or,
		op_and,
		op_lui,
		op_beq,
		op_bne,
		op_blt,
		op_bge,
		op_bltu,
		op_bgeu,
		op_mul,
		op_mulh,
		op_mulhsu,
		op_mulhu,
		op_div,
		op_divu,
		op_rem,
		op_remu
	} alu_op_t;

endpackage

// File: exu_adder.sv
module exu_adder (
	input  logic [exu_pkg::data_width-1:0] a,
	input  logic [exu_pkg::data_width-1:0] b,
	input  logic                           is_sub,
	output logic [exu_pkg::data_width-1:0] sum,
	output logic                           zero_flag,
	output logic                           signed_flag,
	output logic                           unsigned_flag
);

	logic [exu_pkg::data_width-1:0] b_eff;
	logic                           carry;
	logic                           overflow;

	// Subtraction as a plus inverted b plus one.
	assign b_eff = is_sub ? ~b : b;
	assign {carry, sum} = a + b_eff + is_sub;

	assign overflow = (a[exu_pkg::data_width-1] == b_eff[exu_pkg::data_width-1]) &&
		(sum[exu_pkg::data_width-1] != a[exu_pkg::data_width-1]);

	assign zero_flag = sum == '0;
	assign signed_flag = sum[exu_pkg::data_width-1] ^ overflow;
	// No carry out of a subtraction means a borrow.
	assign unsigned_flag = ~carry;

endmodule

// File: exu_alu.sv
module exu_alu (
	input  exu_pkg::alu_op_t               op,
	input  logic [exu_pkg::data_width-1:0] alu_a,
	input  logic [exu_pkg::data_width-1:0] alu_b,
	input  logic [exu_pkg::data_width-1:0] adder_sum,
	input  logic                           signed_flag,
	input  logic                           unsigned_flag,
	output logic [exu_pkg::data_width-1:0] alu_result
);

	logic [4:0] shamt;

	assign shamt = alu_b[4:0];

	always_comb begin
		case (op)
			exu_pkg::op_add,
			exu_pkg::op_sub: begin
				alu_result = adder_sum;
			end
			exu_pkg::op_sll: begin
				alu_result = alu_a << shamt;
			end
			exu_pkg::op_slt: begin
				alu_result = {{(exu_pkg::data_width-1){1'b0}}, signed_flag};
			end
			exu_pkg::op_sltu: begin
				alu_result = {{(exu_pkg::data_width-1){1'b0}}, unsigned_flag};
			end
			exu_pkg::op_xor: begin
				alu_result = alu_a ^ alu_b;
			end
			exu_pkg::op_srl: begin
				alu_result = alu_a >> shamt;
			end
			exu_pkg::op_sra: begin
				alu_result = $signed(alu_a) >>> shamt;
			end
			exu_pkg::op_or: begin
				alu_result = alu_a | alu_b;
			end
			exu_pkg::op_and: begin
				alu_result = alu_a & alu_b;
			end
			exu_pkg::op_lui: begin
				alu_result = alu_b;
			end
			// Branch, multiply and divide codes.
			default: begin
				alu_result = '0;
			end
		endcase
	end

endmodule

// File: exu_bru.sv
module exu_bru (
	input  exu_pkg::alu_op_t op,
	input  logic             zero_flag,
	input  logic             signed_flag,
	input  logic             unsigned_flag,
	output logic             branch_taken
);

	always_comb begin
		case (op)
			exu_pkg::op_beq: begin
				branch_taken = zero_flag;
			end
			exu_pkg::op_bne: begin
				branch_taken = ~zero_flag;
			end
			exu_pkg::op_blt: begin
				branch_taken = signed_flag;
			end
			exu_pkg::op_bge: begin
				branch_taken = ~signed_flag;
			end
			exu_pkg::op_bltu: begin
				branch_taken = unsigned_flag;
			end
			exu_pkg::op_bgeu: begin
				branch_taken = ~unsigned_flag;
			end
			default: begin
				branch_taken = 1'b0;
			end
		endcase
	end

endmodule

// File: exu_mul.sv
module exu_mul (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             start,
	input  logic                             a_signed,
	input  logic                             b_signed,
	input  logic [exu_pkg::data_width-1:0]   multiplicand,
	input  logic [exu_pkg::data_width-1:0]   multiplier,
	output logic                             done,
	output logic [2*exu_pkg::data_width-1:0] product
);

	localparam int count_width = $clog2(exu_pkg::mul_steps + 1);
	localparam int w = exu_pkg::data_width;

	logic [count_width-1:0] count;
	logic                   busy;
	logic                   b_signed_q;
	logic [2*w-1:0]         mcand;
	logic [w-1:0]           mplier;
	logic [2*w-1:0]         acc;
	logic                   last_step;
	logic [2*w-1:0]         addend;

	assign last_step = count == count_width'(1);
	// The top multiplier bit weighs minus 2^31 when b is signed.
	assign addend = (last_step && b_signed_q) ? -mcand : mcand;
	assign product = acc;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				count <= count_width'(exu_pkg::mul_steps);
			end else if (busy) begin
				count <= count - 1'b1;
				if (last_step) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			mcand <= a_signed ? {{w{multiplicand[w-1]}}, multiplicand} : {{w{1'b0}}, multiplicand};
			mplier <= multiplier;
			b_signed_q <= b_signed;
			acc <= '0;
		end else if (busy) begin
			if (mplier[0]) begin
				acc <= acc + addend;
			end
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	a_no_start_busy: assert property (@(posedge clock) disable iff (reset) start |-> !busy);

endmodule

// File: exu_div.sv
module exu_div (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           start,
	input  logic                           is_signed,
	input  logic [exu_pkg::data_width-1:0] dividend,
	input  logic [exu_pkg::data_width-1:0] divisor,
	output logic                           done,
	output logic [exu_pkg::data_width-1:0] quotient,
	output logic [exu_pkg::data_width-1:0] remainder
);

	localparam int count_width = $clog2(exu_pkg::div_steps + 1);
	localparam int w = exu_pkg::data_width;

	logic [count_width-1:0] count;
	logic                   busy;
	logic                   a_neg;
	logic                   b_neg;
	logic [w-1:0]           a_mag;
	logic [w-1:0]           b_mag;
	logic [w:0]             rem_q;
	logic [w-1:0]           quo_q;
	logic [w-1:0]           dvsr_q;
	logic [w-1:0]           dividend_q;
	logic                   neg_quo;
	logic                   neg_rem;
	logic                   by_zero;
	logic                   overflow;
	logic [w:0]             rem_shift;
	logic [w:0]             diff;

	assign a_neg = is_signed && dividend[w-1];
	assign b_neg = is_signed && divisor[w-1];
	assign a_mag = a_neg ? -dividend : dividend;
	assign b_mag = b_neg ? -divisor : divisor;

	// One restoring step. The dividend bits shift in from the quotient register.
	assign rem_shift = {rem_q[w-1:0], quo_q[w-1]};
	assign diff = rem_shift - {1'b0, dvsr_q};

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				count <= count_width'(exu_pkg::div_steps);
			end else if (busy) begin
				count <= count - 1'b1;
				if (count == count_width'(1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			rem_q <= '0;
			quo_q <= a_mag;
			dvsr_q <= b_mag;
			dividend_q <= dividend;
			neg_quo <= a_neg ^ b_neg;
			neg_rem <= a_neg;
			by_zero <= divisor == '0;
			overflow <= is_signed && (dividend == {1'b1, {(w-1){1'b0}}}) && (divisor == '1);
		end else if (busy) begin
			if (!diff[w]) begin
				rem_q <= diff;
				quo_q <= {quo_q[w-2:0], 1'b1};
			end else begin
				rem_q <= rem_shift;
				quo_q <= {quo_q[w-2:0], 1'b0};
			end
		end
	end

	always_comb begin
		if (by_zero) begin
			quotient = '1;
			remainder = dividend_q;
		end else if (overflow) begin
			quotient = dividend_q;
			remainder = '0;
		end else begin
			quotient = neg_quo ? -quo_q : quo_q;
			remainder = neg_rem ? -rem_q[w-1:0] : rem_q[w-1:0];
		end
	end

endmodule

// File: exu.sv
module exu (
	input  logic                           clock,
	input  logic                           reset,
	input  logic [exu_pkg::data_width-1:0] pc,
	input  logic [exu_pkg::data_width-1:0] src1,
	input  logic [exu_pkg::data_width-1:0] src2,
	input  logic [exu_pkg::data_width-1:0] imm,
	input  exu_pkg::alu_op_t               op,
	input  logic                           use_src2,
	input  logic                           pc_add_imm,
	input  logic                           id_to_ex,
	input  logic                           ex_to_wb,
	output logic                           branch_taken,
	output logic [exu_pkg::data_width-1:0] adder_sum,
	output logic [exu_pkg::data_width-1:0] adder_pc,
	output logic [exu_pkg::data_width-1:0] exu_result,
	output logic                           exu_stall,
	output logic                           exu_finished
);

	logic [exu_pkg::data_width-1:0]   alu_a;
	logic [exu_pkg::data_width-1:0]   alu_b;
	logic [exu_pkg::data_width-1:0]   alu_result;
	logic                             adder_sub;
	logic                             zero_flag;
	logic                             signed_flag;
	logic                             unsigned_flag;
	logic                             is_mul;
	logic                             is_div;
	logic                             start_pulse;
	logic                             mul_done;
	logic                             div_done;
	logic [2*exu_pkg::data_width-1:0] product;
	logic [exu_pkg::data_width-1:0]   quotient;
	logic [exu_pkg::data_width-1:0]   remainder;
	logic [exu_pkg::data_width-1:0]   mul_result;
	logic [exu_pkg::data_width-1:0]   div_result;
	logic                             alu_load;
	logic                             finish_now;

	assign alu_a = src1;
	assign alu_b = use_src2 ? src2 : imm;

	assign adder_sub = op inside {exu_pkg::op_sub, exu_pkg::op_slt, exu_pkg::op_sltu,
		exu_pkg::op_beq, exu_pkg::op_bne, exu_pkg::op_blt, exu_pkg::op_bge,
		exu_pkg::op_bltu, exu_pkg::op_bgeu};
	assign is_mul = op inside {exu_pkg::op_mul, exu_pkg::op_mulh, exu_pkg::op_mulhsu,
		exu_pkg::op_mulhu};
	assign is_div = op inside {exu_pkg::op_div, exu_pkg::op_divu, exu_pkg::op_rem,
		exu_pkg::op_remu};

	exu_adder u_adder_src (
		.a(alu_a),
		.b(alu_b),
		.is_sub(adder_sub),
		.sum(adder_sum),
		.zero_flag(zero_flag),
		.signed_flag(signed_flag),
		.unsigned_flag(unsigned_flag)
	);

	// Next PC or branch and jump target.
	exu_adder u_adder_pc (
		.a(pc),
		.b(pc_add_imm ? imm : exu_pkg::data_width'(4)),
		.is_sub(1'b0),
		.sum(adder_pc),
		.zero_flag(),
		.signed_flag(),
		.unsigned_flag()
	);

	exu_bru u_bru (
		.op(op),
		.zero_flag(zero_flag),
		.signed_flag(signed_flag),
		.unsigned_flag(unsigned_flag),
		.branch_taken(branch_taken)
	);

	exu_alu u_alu (
		.op(op),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.adder_sum(adder_sum),
		.signed_flag(signed_flag),
		.unsigned_flag(unsigned_flag),
		.alu_result(alu_result)
	);

	exu_mul u_mul (
		.clock(clock),
		.reset(reset),
		.start(start_pulse && is_mul),
		.a_signed(op != exu_pkg::op_mulhu),
		.b_signed(op == exu_pkg::op_mul || op == exu_pkg::op_mulh),
		.multiplicand(alu_a),
		.multiplier(alu_b),
		.done(mul_done),
		.product(product)
	);

	exu_div u_div (
		.clock(clock),
		.reset(reset),
		.start(start_pulse && is_div),
		.is_signed(op == exu_pkg::op_div || op == exu_pkg::op_rem),
		.dividend(alu_a),
		.divisor(alu_b),
		.done(div_done),
		.quotient(quotient),
		.remainder(remainder)
	);

	// Only mul takes the low half.
	assign mul_result = (op == exu_pkg::op_mul) ? product[exu_pkg::data_width-1:0] :
		product[2*exu_pkg::data_width-1:exu_pkg::data_width];
	assign div_result = (op == exu_pkg::op_rem || op == exu_pkg::op_remu) ? remainder : quotient;

	assign finish_now = alu_load || mul_done || div_done;

	always_ff @(posedge clock) begin
		if (reset) begin
			start_pulse <= 1'b0;
			alu_load <= 1'b0;
			exu_stall <= 1'b0;
			exu_finished <= 1'b0;
			exu_result <= '0;
		end else begin
			start_pulse <= id_to_ex;
			// The ALU result is captured one cycle after the start pulse.
			alu_load <= start_pulse && !is_mul && !is_div;
			if (id_to_ex) begin
				exu_stall <= 1'b1;
			end else if (finish_now) begin
				exu_stall <= 1'b0;
			end
			if (finish_now) begin
				exu_finished <= 1'b1;
			end else if (ex_to_wb) begin
				exu_finished <= 1'b0;
			end
			if (mul_done) begin
				exu_result <= mul_result;
			end else if (div_done) begin
				exu_result <= div_result;
			end else if (alu_load) begin
				exu_result <= alu_result;
			end
		end
	end

	// A new op may only arrive when the stage is idle or its result is released that edge.
	a_issue_idle: assert property (@(posedge clock) disable iff (reset)
		id_to_ex |-> !exu_stall && (!exu_finished || ex_to_wb));

endmodule

// File: tb_exu_checker.sv
module tb_exu_checker (
	input  logic                           clock,
	input  logic                           reset,
	input  exu_pkg::alu_op_t               op,
	input  logic                           id_to_ex,
	input  logic                           ex_to_wb,
	input  logic                           branch_taken,
	input  logic [exu_pkg::data_width-1:0] adder_sum,
	input  logic [exu_pkg::data_width-1:0] adder_pc,
	input  logic [exu_pkg::data_width-1:0] exu_result,
	input  logic                           exu_stall,
	input  logic                           exu_finished,
	input  logic [exu_pkg::data_width-1:0] exp_result,
	input  logic                           exp_taken,
	input  logic [exu_pkg::data_width-1:0] exp_sum,
	input  logic [exu_pkg::data_width-1:0] exp_pc,
	output int                             value_errors,
	output int                             timing_errors
);

	logic [exu_pkg::data_width-1:0] want_result;
	logic [exu_pkg::data_width-1:0] held_result;
	logic                           single_cycle;
	logic                           pending;
	logic                           started;
	logic                           fin_prev;
	logic                           release_prev;
	int                             since;

	initial begin
		value_errors = 0;
		timing_errors = 0;
		pending = 1'b0;
		started = 1'b0;
		fin_prev = 1'b0;
		release_prev = 1'b0;
		since = 0;
	end

	// All values are sampled as they stood just before the edge.
	always @(posedge clock) begin
		if (!reset) begin
			if (!started && (exu_finished || exu_stall)) begin
				$display("Stage busy after reset before any operation was issued");
				timing_errors = timing_errors + 1;
			end
			if (id_to_ex) begin
				started = 1'b1;
				pending = 1'b1;
				since = 0;
				want_result = exp_result;
				single_cycle = !(op inside {exu_pkg::op_mul, exu_pkg::op_mulh,
					exu_pkg::op_mulhsu, exu_pkg::op_mulhu, exu_pkg::op_div,
					exu_pkg::op_divu, exu_pkg::op_rem, exu_pkg::op_remu});
			end else begin
				since = since + 1;
			end
			if (pending && !exu_finished) begin
				if (branch_taken !== exp_taken) begin
					$display("FAILED %0t: %s branch_taken %b, expected %b", $time,
						op.name(), branch_taken, exp_taken);
					value_errors = value_errors + 1;
				end
				if (adder_sum !== exp_sum || adder_pc !== exp_pc) begin
					$display("FAILED %0t: %s adder_sum %h adder_pc %h, expected %h %h",
						$time, op.name(), adder_sum, adder_pc, exp_sum, exp_pc);
					value_errors = value_errors + 1;
				end
				if (since >= 1 && !exu_stall) begin
					$display("FAILED %0t: exu_stall low while %s in flight", $time, op.name());
					timing_errors = timing_errors + 1;
				end
			end
			if (exu_finished && !fin_prev && pending) begin
				pending = 1'b0;
				held_result = exu_result;
				if (exu_result !== want_result) begin
					$display("FAILED %0t: %s result %h, expected %h", $time, op.name(),
						exu_result, want_result);
					value_errors = value_errors + 1;
				end
				// Finished set on edge E+2 is first sampled at edge E+3.
				if (single_cycle && since != 3) begin
					$display("FAILED %0t: %s finished after %0d cycles, expected 2",
						$time, op.name(), since - 1);
					timing_errors = timing_errors + 1;
				end
				if (exu_stall) begin
					$display("FAILED %0t: exu_stall still high with result ready", $time);
					timing_errors = timing_errors + 1;
				end
			end else if (exu_finished && exu_result !== held_result) begin
				$display("FAILED %0t: held result changed to %h from %h", $time,
					exu_result, held_result);
				value_errors = value_errors + 1;
			end
			if (release_prev && exu_finished) begin
				$display("FAILED %0t: exu_finished stayed high after writeback", $time);
				timing_errors = timing_errors + 1;
			end
			if (fin_prev && !exu_finished && !release_prev) begin
				$display("FAILED %0t: exu_finished fell before writeback took the result",
					$time);
				timing_errors = timing_errors + 1;
			end
			release_prev = exu_finished && ex_to_wb;
			fin_prev = exu_finished;
		end
	end

endmodule

// File: tb_exu.sv
module tb_exu;

	localparam int test_count = 600;
	localparam int reset_cycles = 10;
	localparam int timeout_cycles = test_count * 40 + reset_cycles;

	logic                           clock;
	logic                           reset;
	logic [31:0]                    pc;
	logic [31:0]                    src1;
	logic [31:0]                    src2;
	logic [31:0]                    imm;
	exu_pkg::alu_op_t               op;
	logic                           use_src2;
	logic                           pc_add_imm;
	logic                           id_to_ex;
	logic                           ex_to_wb;
	logic                           branch_taken;
	logic [31:0]                    adder_sum;
	logic [31:0]                    adder_pc;
	logic [31:0]                    exu_result;
	logic                           exu_stall;
	logic                           exu_finished;
	logic [31:0]                    exp_result;
	logic                           exp_taken;
	logic [31:0]                    exp_sum;
	logic [31:0]                    exp_pc;
	int                             value_errors;
	int                             timing_errors;
	int                             cycles;
	int                             tests;
	logic [31:0]                    corner_vals [3];

	exu u_exu (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.src1(src1),
		.src2(src2),
		.imm(imm),
		.op(op),
		.use_src2(use_src2),
		.pc_add_imm(pc_add_imm),
		.id_to_ex(id_to_ex),
		.ex_to_wb(ex_to_wb),
		.branch_taken(branch_taken),
		.adder_sum(adder_sum),
		.adder_pc(adder_pc),
		.exu_result(exu_result),
		.exu_stall(exu_stall),
		.exu_finished(exu_finished)
	);

	tb_exu_checker u_checker (
		.clock(clock),
		.reset(reset),
		.op(op),
		.id_to_ex(id_to_ex),
		.ex_to_wb(ex_to_wb),
		.branch_taken(branch_taken),
		.adder_sum(adder_sum),
		.adder_pc(adder_pc),
		.exu_result(exu_result),
		.exu_stall(exu_stall),
		.exu_finished(exu_finished),
		.exp_result(exp_result),
		.exp_taken(exp_taken),
		.exp_sum(exp_sum),
		.exp_pc(exp_pc),
		.value_errors(value_errors),
		.timing_errors(timing_errors)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == timeout_cycles) begin
			$display("Timeout: run did not complete within %0d cycles", timeout_cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Returns the branch outcome above the 32-bit result.
	function automatic logic [32:0] exu_model(input exu_pkg::alu_op_t f, input logic [31:0] a,
		input logic [31:0] b);
		logic [63:0]        sa;
		logic [63:0]        sb;
		logic [63:0]        za;
		logic [63:0]        zb;
		logic [63:0]        p;
		logic [31:0]        r;
		logic               t;
		logic               ovf;
		logic signed [31:0] q_s;
		logic signed [31:0] r_s;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		za = {32'b0, a};
		zb = {32'b0, b};
		ovf = a == 32'h8000_0000 && b == 32'hffff_ffff;
		r = 32'b0;
		t = 1'b0;
		p = 64'b0;
		// Signed quotient and remainder, computed apart from the unsigned special cases.
		if (b != 32'b0 && !ovf) begin
			q_s = $signed(a) / $signed(b);
			r_s = $signed(a) % $signed(b);
		end else begin
			q_s = '0;
			r_s = '0;
		end
		case (f)
			exu_pkg::op_add: r = a + b;
			exu_pkg::op_sub: r = a - b;
			exu_pkg::op_sll: r = a << b[4:0];
			exu_pkg::op_slt: r = {31'b0, $signed(a) < $signed(b)};
			exu_pkg::op_sltu: r = {31'b0, a < b};
			exu_pkg::op_xor: r = a ^ b;
			exu_pkg::op_srl: r = a >> b[4:0];
			exu_pkg::op_sra: r = $signed(a) >>> b[4:0];
			exu_pkg::op_or: r = a | b;
			exu_pkg::op_and: r = a & b;
			exu_pkg::op_lui: r = b;
			exu_pkg::op_beq: t = a == b;
			exu_pkg::op_bne: t = a != b;
			exu_pkg::op_blt: t = $signed(a) < $signed(b);
			exu_pkg::op_bge: t = $signed(a) >= $signed(b);
			exu_pkg::op_bltu: t = a < b;
			exu_pkg::op_bgeu: t = a >= b;
			exu_pkg::op_mul: begin
				p = sa * sb;
				r = p[31:0];
			end
			exu_pkg::op_mulh: begin
				p = sa * sb;
				r = p[63:32];
			end
			exu_pkg::op_mulhsu: begin
				p = sa * zb;
				r = p[63:32];
			end
			exu_pkg::op_mulhu: begin
				p = za * zb;
				r = p[63:32];
			end
			exu_pkg::op_div: r = (b == 0) ? '1 : ovf ? a : q_s;
			exu_pkg::op_divu: r = (b == 0) ? '1 : a / b;
			exu_pkg::op_rem: r = (b == 0) ? a : ovf ? 32'b0 : r_s;
			exu_pkg::op_remu: r = (b == 0) ? a : a % b;
			default: r = 32'b0;
		endcase
		return {t, r};
	endfunction

	task automatic run_op(input exu_pkg::alu_op_t f, input logic [31:0] a, input logic [31:0] b,
		input logic sel, input int wb_delay);
		logic [31:0] pc_v;
		logic [31:0] other;
		logic        add_imm;
		logic [32:0] m;
		pc_v = $urandom & 32'hffff_fffc;
		other = $urandom;
		add_imm = $urandom_range(0, 1);
		m = exu_model(f, a, b);
		@(posedge clock);
		op <= f;
		src1 <= a;
		use_src2 <= sel;
		src2 <= sel ? b : other;
		imm <= sel ? other : b;
		pc <= pc_v;
		pc_add_imm <= add_imm;
		exp_result <= m[31:0];
		exp_taken <= m[32];
		exp_sum <= (f inside {exu_pkg::op_sub, exu_pkg::op_slt, exu_pkg::op_sltu,
			exu_pkg::op_beq, exu_pkg::op_bne, exu_pkg::op_blt, exu_pkg::op_bge,
			exu_pkg::op_bltu, exu_pkg::op_bgeu}) ? a - b : a + b;
		exp_pc <= pc_v + (add_imm ? (sel ? other : b) : 32'd4);
		id_to_ex <= 1'b1;
		@(posedge clock);
		id_to_ex <= 1'b0;
		do begin
			@(posedge clock);
		end while (!exu_finished);
		repeat (wb_delay) @(posedge clock);
		ex_to_wb <= 1'b1;
		@(posedge clock);
		ex_to_wb <= 1'b0;
		tests = tests + 1;
	endtask

	initial begin
		void'($urandom(32'h86a51b3c));
		corner_vals = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};
		clock = 1'b0;
		reset = 1'b1;
		pc = '0;
		src1 = '0;
		src2 = '0;
		imm = '0;
		op = exu_pkg::op_add;
		use_src2 = 1'b0;
		pc_add_imm = 1'b0;
		id_to_ex = 1'b0;
		ex_to_wb = 1'b0;
		exp_result = '0;
		exp_taken = 1'b0;
		exp_sum = '0;
		exp_pc = '0;
		cycles = 0;
		tests = 0;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;
		// Stage must stay idle for a while after reset.
		repeat (3) @(posedge clock);
		for (int i = 0; i < 25; i++) begin
			for (int j = 0; j < 3; j++) begin
				for (int k = 0; k < 3; k++) begin
					run_op(exu_pkg::alu_op_t'(i), corner_vals[j], corner_vals[k],
						(j + k) % 2, $urandom_range(0, 3));
				end
			end
		end
		while (tests < test_count) begin
			logic [31:0] a;
			logic [31:0] b;
			a = $urandom;
			b = ($urandom_range(0, 7) == 0) ? a : $urandom;
			// Long writeback hold now and then.
			run_op(exu_pkg::alu_op_t'($urandom_range(0, 24)), a, b, $urandom_range(0, 1),
				(tests % 40 == 0) ? 8 : $urandom_range(0, 3));
		end
		repeat (3) @(posedge clock);
		$display("Tests %0d, value errors %0d, timing errors %0d", tests, value_errors,
			timing_errors);
		if (value_errors == 0 && timing_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: filelist.f
exu_pkg.sv
exu_adder.sv
exu_alu.sv
exu_bru.sv
exu_mul.sv
exu_div.sv
exu.sv
tb_exu_checker.sv
tb_exu.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_exu
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
